//--- video_consts.svh
// frame size, window limits, tile counts, fetch spacings and bandwidth codes
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// whole frame in clocks per line and lines per frame
`define VID_HTOTAL 9'd448
`define VID_VTOTAL 9'd320

// raster res 0 is 256x192
`define VID_HBEG_0 9'd140
`define VID_HEND_0 9'd396
`define VID_VBEG_0 9'd80
`define VID_VEND_0 9'd272
`define VID_XTILES_0 6'd33

// raster res 1 is 320x200
`define VID_HBEG_1 9'd108
`define VID_HEND_1 9'd428
`define VID_VBEG_1 9'd76
`define VID_VEND_1 9'd276
`define VID_XTILES_1 6'd41

// raster res 2 is 320x240
`define VID_HBEG_2 9'd108
`define VID_HEND_2 9'd428
`define VID_VBEG_2 9'd56
`define VID_VEND_2 9'd296
`define VID_XTILES_2 6'd41

// raster res 3 is 360x288, no border at all
`define VID_HBEG_3 9'd88
`define VID_HEND_3 9'd448
`define VID_VBEG_3 9'd32
`define VID_VEND_3 9'd320
`define VID_XTILES_3 6'd46

// clocks between two fetch strobes
`define VID_FSPACE_ZX 5'd8
`define VID_FSPACE_HC 5'd4
`define VID_FSPACE_XC 5'd2
`define VID_FSPACE_TX 5'd4

// upper two bits give total cycles (11 = 8, 01 = 4, 00 = 2), lower three the cycles used
`define VID_BW_ZX 5'b11001
`define VID_BW_HC 5'b01001
`define VID_BW_XC 5'b00001
`define VID_BW_TX 5'b11100

`endif

//--- video_pkg.sv
// width typedefs, video mode enum, config, window and request structs
`default_nettype none

package video_pkg;

	typedef logic [20:0] vid_addr_t;	// dram word address
	typedef logic [15:0] vid_data_t;	// dram word
	typedef logic [8:0] vid_coord_t;	// raster x or y
	typedef logic [7:0] vid_col_t;	// fetch column within a line
	typedef logic [4:0] vid_bw_t;	// dram bandwidth code

	// one entry per layout, doubles as the render mode
	typedef enum logic [1:0] {
		mode_zx = 2'd0,	// zx screen with attributes
		mode_hc = 2'd1,	// 16 colours, 4 bpp
		mode_xc = 2'd2,	// 256 colours, 8 bpp
		mode_tx = 2'd3	// text with glyph lookup
	} vid_mode_e;

	// registered copy of the cpu side video config
	typedef struct packed {
		logic [7:0] vpage;	// page bits of the dram address
		logic [1:0] rres;	// raster resolution index
		logic nogfx;	// no fetches at all
		vid_mode_e mode;
	} vid_cfg_t;

	// decoded raster window and fetch pacing
	typedef struct packed {
		vid_coord_t hbeg;
		vid_coord_t hend;	// first column past the window
		vid_coord_t vbeg;
		vid_coord_t vend;	// first line past the window
		logic [5:0] x_tiles;
		logic [4:0] fetch_space;	// clocks per fetch strobe
		vid_bw_t bw;
	} vid_win_t;

	// single cycle dram read strobe
	typedef struct packed {
		logic valid;
		vid_addr_t addr;
		vid_bw_t bw;
	} vid_req_t;

endpackage

`default_nettype wire

//--- video_mode.sv
// video mode decoder for window limits, fetch pacing, bandwidth and pixel rate
`default_nettype none

`include "video_consts.svh"

module video_mode import video_pkg::*; (
	input wire clk,
	input wire rst,
	input wire vid_cfg_t cfg,
	input wire line_start,
	output vid_win_t win,
	output logic tv_hires,
	output logic line_hires
);

	// raster resolution picks the window and the tile count
	always_comb begin
		unique case (cfg.rres)
			2'd0: begin	// 256x192
				win.hbeg = `VID_HBEG_0;
				win.hend = `VID_HEND_0;
				win.vbeg = `VID_VBEG_0;
				win.vend = `VID_VEND_0;
				win.x_tiles = `VID_XTILES_0;
			end
			2'd1: begin	// 320x200
				win.hbeg = `VID_HBEG_1;
				win.hend = `VID_HEND_1;
				win.vbeg = `VID_VBEG_1;
				win.vend = `VID_VEND_1;
				win.x_tiles = `VID_XTILES_1;
			end
			2'd2: begin	// 320x240
				win.hbeg = `VID_HBEG_2;
				win.hend = `VID_HEND_2;
				win.vbeg = `VID_VBEG_2;
				win.vend = `VID_VEND_2;
				win.x_tiles = `VID_XTILES_2;
			end
			default: begin	// 360x288, full frame width
				win.hbeg = `VID_HBEG_3;
				win.hend = `VID_HEND_3;
				win.vbeg = `VID_VBEG_3;
				win.vend = `VID_VEND_3;
				win.x_tiles = `VID_XTILES_3;
			end
		endcase
	end

	// mode picks the fetch rate and the dram share
	always_comb begin
		unique case (cfg.mode)
			mode_zx: begin
				win.fetch_space = `VID_FSPACE_ZX;	// 1 of 8
				win.bw = `VID_BW_ZX;
			end
			mode_hc: begin
				win.fetch_space = `VID_FSPACE_HC;	// 1 of 4
				win.bw = `VID_BW_HC;
			end
			mode_xc: begin
				win.fetch_space = `VID_FSPACE_XC;	// 1 of 2
				win.bw = `VID_BW_XC;
			end
			default: begin
				// text needs 4 of 8 for char, attr and two glyph bytes
				win.fetch_space = `VID_FSPACE_TX;
				win.bw = `VID_BW_TX;
			end
		endcase
	end

	// only text runs at the doubled pixel rate
	assign tv_hires = (cfg.mode == mode_tx);

	// pixel rate is frozen for a whole line
	always_ff @(posedge clk) begin
		if (rst)
			line_hires <= 1'b0;
		else if (line_start)
			line_hires <= tv_hires;	// picked up once per line
	end

endmodule

`default_nettype wire

//--- video_raster.sv
// raster counters, active window flags, line and frame start strobes
`default_nettype none

`include "video_consts.svh"

module video_raster import video_pkg::*; (
	input wire clk,
	input wire rst,
	input wire vid_win_t win,
	output vid_coord_t hcnt,
	output vid_coord_t vcnt,
	output logic h_active,
	output logic v_active,
	output logic line_start,
	output logic frame_start
);

	logic h_last;	// last clock of the line
	logic v_last;	// last line of the frame

	assign h_last = (hcnt == `VID_HTOTAL - 9'd1);
	assign v_last = (vcnt == `VID_VTOTAL - 9'd1);

	// one free running clock per pixel column
	always_ff @(posedge clk) begin
		if (rst) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (h_last) begin
			hcnt <= '0;
			if (v_last)
				vcnt <= '0;	// frame wrap
			else
				vcnt <= vcnt + 9'd1;
		end else begin
			hcnt <= hcnt + 9'd1;
		end
	end

	// window compare with exclusive end limits
	assign h_active = (hcnt >= win.hbeg) && (hcnt < win.hend);
	assign v_active = (vcnt >= win.vbeg) && (vcnt < win.vend);

	// counters sit at zero in reset and the strobes stay quiet there
	assign line_start = ~rst & (hcnt == '0);
	assign frame_start = line_start & (vcnt == '0);

	// horizontal counter never leaves the frame
	a_hcnt_range: assert property (@(posedge clk) disable iff (rst)
		hcnt < `VID_HTOTAL)
		else $error("hcnt out of range %0d", hcnt);

endmodule

`default_nettype wire

//--- video_addr.sv
// dram address composer for the zx, 16c, 256c and text layouts
`default_nettype none

module video_addr import video_pkg::*; (
	input wire vid_mode_e mode,
	input wire [7:0] vpage,
	input wire vid_col_t cnt_col,
	input wire vid_coord_t cnt_row,
	input wire vid_data_t txt_char,	// char pair from phase 0
	output vid_addr_t addr
);

	logic [11:0] zx_gfx;
	logic [11:0] zx_atr;
	logic [13:0] tx_low;
	vid_addr_t addr_zx;
	vid_addr_t addr_hc;
	vid_addr_t addr_xc;
	vid_addr_t addr_tx;

	// zx bitmap has the thirds and char lines swapped around
	assign zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};	// attrs above the bitmap
	assign addr_zx = {vpage, 1'b0, cnt_col[0] ? zx_atr : zx_gfx};	// odd col is attr

	// linear layouts, page grain depends on line length
	assign addr_hc = {vpage[7:3], cnt_row, cnt_col[6:0]};	// 128 words per line
	assign addr_xc = {vpage[7:4], cnt_row, cnt_col};	// 256 words per line

	// text cycles through char, attr, glyph0, glyph1
	always_comb begin
		unique case (cnt_col[1:0])
			2'd0: tx_low = {vpage[0], cnt_row[8:3], 1'b0, cnt_col[7:2]};	// char codes
			2'd1: tx_low = {vpage[0], cnt_row[8:3], 1'b1, cnt_col[7:2]};	// attributes
			// font lives in the other half page
			2'd2: tx_low = {~vpage[0], 3'b000, txt_char[7:0], cnt_row[2:1]};
			default: tx_low = {~vpage[0], 3'b000, txt_char[15:8], cnt_row[2:1]};
		endcase
	end

	assign addr_tx = {vpage[7:1], tx_low};

	// layout select
	always_comb begin
		unique case (mode)
			mode_zx: addr = addr_zx;
			mode_hc: addr = addr_hc;
			mode_xc: addr = addr_xc;
			default: addr = addr_tx;
		endcase
	end

endmodule

`default_nettype wire

//--- video_fetch.sv
// fetch pacing, column and row counters, read strobe and text char capture
`default_nettype none

module video_fetch import video_pkg::*; (
	input wire clk,
	input wire rst,
	input wire vid_win_t win,
	input wire vid_cfg_t cfg,
	input wire line_start,
	input wire frame_start,
	input wire h_active,
	input wire v_active,
	input wire mem_rd_stb,
	input wire vid_data_t mem_rd_data,
	input wire vid_addr_t addr,
	output vid_req_t req,
	output vid_col_t cnt_col,
	output vid_coord_t cnt_row,
	output vid_data_t txt_char
);

	logic [4:0] phase;	// clocks since last fetch slot
	logic last_phase;
	logic fire;
	logic pend;	// read in flight
	logic cap_pend;	// in flight read is a text char word
	logic v_act_q;	// previous line was active

	assign last_phase = (phase >= win.fetch_space - 5'd1);	// also catches a shrunk spacing

	// strobe on the last phase, inside the window only
	assign fire = (phase == win.fetch_space - 5'd1) & h_active & v_active & ~cfg.nogfx;

	assign req = '{valid: fire, addr: addr, bw: win.bw};

	always_ff @(posedge clk) begin
		if (rst || line_start)
			phase <= '0;	// realign every line
		else if (last_phase)
			phase <= '0;
		else
			phase <= phase + 5'd1;
	end

	always_ff @(posedge clk) begin
		if (rst || line_start)
			cnt_col <= '0;
		else if (fire)
			cnt_col <= cnt_col + 8'd1;	// next column after each read
	end

	// row counts active lines only
	always_ff @(posedge clk) begin
		if (rst) begin
			v_act_q <= 1'b0;
			cnt_row <= '0;
		end else begin
			v_act_q <= v_active;
			if (frame_start)
				cnt_row <= '0;
			else if (line_start && v_act_q)
				cnt_row <= cnt_row + 9'd1;
		end
	end

	// track the one outstanding read
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			cap_pend <= 1'b0;
		end else if (fire) begin
			pend <= 1'b1;	// reply may land on this same clock
			cap_pend <= (cfg.mode == mode_tx) && (cnt_col[1:0] == 2'd0);
		end else if (mem_rd_stb) begin
			pend <= 1'b0;
			cap_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rd_stb && cap_pend)
			txt_char <= mem_rd_data;	// char pair for the glyph phases
	end

	// memory must answer before the next strobe goes out
	a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
		fire |-> (!pend || mem_rd_stb))
		else $error("second request issued with a read outstanding");

endmodule

`default_nettype wire

//--- video_top.sv
// video front end top with config register, mode, raster, fetch and address blocks
`default_nettype none

module video_top import video_pkg::*; (
	input wire clk,
	input wire rst,
	input wire cfg_stb,
	input wire [7:0] cfg_vpage,
	input wire [7:0] cfg_vconf,	// [1:0] mode, [5] nogfx, [7:6] rres
	input wire mem_rd_stb,
	input wire vid_data_t mem_rd_data,
	output vid_req_t req,
	output logic line_start,
	output logic frame_start,
	output logic line_hires,
	output logic h_active,
	output logic v_active
);

	vid_cfg_t cfg;
	vid_win_t win;
	vid_col_t cnt_col;
	vid_coord_t cnt_row;
	vid_data_t txt_char;
	vid_addr_t addr;

	// cpu strobe loads page and mode that apply from the next clock
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;	// zx, res 0, gfx on
		end else if (cfg_stb) begin
			cfg.vpage <= cfg_vpage;
			cfg.rres <= cfg_vconf[7:6];
			cfg.nogfx <= cfg_vconf[5];
			cfg.mode <= vid_mode_e'(cfg_vconf[1:0]);
		end
	end

	video_mode u_video_mode (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.line_start(line_start),
		.win(win),
		.tv_hires(),	// only the per line copy leaves the block
		.line_hires(line_hires)
	);

	video_raster u_video_raster (
		.clk(clk),
		.rst(rst),
		.win(win),
		.hcnt(),	// raster position stays inside the block
		.vcnt(),
		.h_active(h_active),
		.v_active(v_active),
		.line_start(line_start),
		.frame_start(frame_start)
	);

	video_fetch u_video_fetch (
		.clk(clk),
		.rst(rst),
		.win(win),
		.cfg(cfg),
		.line_start(line_start),
		.frame_start(frame_start),
		.h_active(h_active),
		.v_active(v_active),
		.mem_rd_stb(mem_rd_stb),
		.mem_rd_data(mem_rd_data),
		.addr(addr),
		.req(req),
		.cnt_col(cnt_col),
		.cnt_row(cnt_row),
		.txt_char(txt_char)
	);

	video_addr u_video_addr (
		.mode(cfg.mode),
		.vpage(cfg.vpage),
		.cnt_col(cnt_col),
		.cnt_row(cnt_row),
		.txt_char(txt_char),
		.addr(addr)
	);

endmodule

`default_nettype wire

//--- tb_video.sv
// testbench for the video front end with clock, reset, memory responder, stimulus and checks
`default_nettype none

`include "video_consts.svh"

module tb_video import video_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int SEED = 28186;
	localparam int HTOTAL = 448;
	localparam int VTOTAL = 320;
	localparam int FRAME_CLKS = HTOTAL * VTOTAL;
	localparam int N_FRAMES = 5;	// one per raster res, then a nogfx frame
	localparam int WATCHDOG = (RESET_CYCLES + (N_FRAMES + 1) * FRAME_CLKS) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic cfg_stb;
	logic [7:0] cfg_vpage;
	logic [7:0] cfg_vconf;
	logic mem_rd_stb;
	vid_data_t mem_rd_data;
	vid_req_t req;
	logic line_start;
	logic frame_start;
	logic line_hires;
	logic h_active;
	logic v_active;

	// model of the config register, owned by the stimulus
	vid_mode_e cur_mode = mode_zx;
	int cur_rres = 0;
	logic cur_nogfx = 1'b0;
	int cur_vpage = 0;

	// raster and fetch model, owned by the monitor
	vid_coord_t tb_h;
	vid_coord_t tb_v;
	vid_coord_t hb;
	vid_coord_t he;
	vid_coord_t vb;
	vid_coord_t ve;
	logic [4:0] fs;
	vid_bw_t bw;
	logic h_in;
	logic v_in;
	logic line_act;	// line seen inside the vertical window
	logic exp_hires;
	logic seen_line;
	logic seen_frame;
	int line_gap;
	int frame_gap;
	int tb_col;
	int tb_row;
	int req_cnt;
	int line_exp;
	int req_total = 0;
	int exp_char = 0;	// char pair last handed out
	vid_addr_t exp_addr;
	vid_data_t rsp_new = '0;
	logic [1:0] rsp_vld = 2'b00;	// responder delay line
	vid_data_t rsp_dat0 = '0;
	vid_data_t rsp_dat1 = '0;

	video_top u_video_top (
		.clk(clk),
		.rst(rst),
		.cfg_stb(cfg_stb),
		.cfg_vpage(cfg_vpage),
		.cfg_vconf(cfg_vconf),
		.mem_rd_stb(mem_rd_stb),
		.mem_rd_data(mem_rd_data),
		.req(req),
		.line_start(line_start),
		.frame_start(frame_start),
		.line_hires(line_hires),
		.h_active(h_active),
		.v_active(v_active)
	);

	task automatic stop_failed();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input int exp_v, input int got_v);
		$display("Mismatch at time %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_v, got_v);
		stop_failed();
	endtask

	task automatic failure(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		stop_failed();
	endtask

	// window limits per raster res
	function automatic void window_limits(input int r, output vid_coord_t h0,
		output vid_coord_t h1, output vid_coord_t v0, output vid_coord_t v1);
		case (r)
			0: begin
				h0 = `VID_HBEG_0;
				h1 = `VID_HEND_0;
				v0 = `VID_VBEG_0;
				v1 = `VID_VEND_0;
			end
			1: begin
				h0 = `VID_HBEG_1;
				h1 = `VID_HEND_1;
				v0 = `VID_VBEG_1;
				v1 = `VID_VEND_1;
			end
			2: begin
				h0 = `VID_HBEG_2;
				h1 = `VID_HEND_2;
				v0 = `VID_VBEG_2;
				v1 = `VID_VEND_2;
			end
			default: begin
				h0 = `VID_HBEG_3;
				h1 = `VID_HEND_3;
				v0 = `VID_VBEG_3;
				v1 = `VID_VEND_3;
			end
		endcase
	endfunction

	// fetch spacing and bandwidth code per mode
	function automatic void mode_rate(input vid_mode_e m, output logic [4:0] sp, output vid_bw_t code);
		case (m)
			mode_zx: begin
				sp = `VID_FSPACE_ZX;
				code = `VID_BW_ZX;
			end
			mode_hc: begin
				sp = `VID_FSPACE_HC;
				code = `VID_BW_HC;
			end
			mode_xc: begin
				sp = `VID_FSPACE_XC;
				code = `VID_BW_XC;
			end
			default: begin
				sp = `VID_FSPACE_TX;
				code = `VID_BW_TX;
			end
		endcase
	endfunction

	// expected dram word address, written as bit weights
	function automatic vid_addr_t layout_addr(input vid_mode_e m, input int pg, input int col,
		input int row, input int chr);
		int a;
		case (m)
			mode_zx: begin
				if (col % 2 == 1)	// attr area starts at 0xc00
					a = pg * 8192 + 3072 + (row / 8 % 32) * 16 + col / 2 % 16;
				else
					a = pg * 8192 + (row / 64 % 4) * 1024 + (row % 8) * 128
						+ (row / 8 % 8) * 16 + col / 2 % 16;
			end
			mode_hc: a = pg / 8 * 65536 + row * 128 + col % 128;
			mode_xc: a = pg / 16 * 131072 + row * 256 + col % 256;
			default: begin
				a = pg / 2 * 16384;
				case (col % 4)
					0: a = a + pg % 2 * 8192 + row / 8 * 128 + col / 4 % 64;
					1: a = a + pg % 2 * 8192 + row / 8 * 128 + 64 + col / 4 % 64;
					2: a = a + (1 - pg % 2) * 8192 + chr % 256 * 4 + row / 2 % 4;	// glyph0
					default: a = a + (1 - pg % 2) * 8192 + chr / 256 % 256 * 4 + row / 2 % 4;
				endcase
			end
		endcase
		return vid_addr_t'(a);
	endfunction

	task automatic line_sync();
		do
			@(negedge clk);
		while (!line_start);
	endtask

	task automatic frame_sync();
		do
			@(negedge clk);
		while (!frame_start);
	endtask

	// cpu write, model follows once the register has it
	task automatic write_config(input int mode_v, input int rres_v, input logic nogfx_v,
		input int pg, input int delay);
		repeat (delay) @(posedge clk);
		#1;
		cfg_stb = 1'b1;
		cfg_vpage = 8'(pg);
		cfg_vconf = {2'(rres_v), nogfx_v, 3'b000, 2'(mode_v)};
		@(posedge clk);
		#1;
		cfg_stb = 1'b0;
		cur_mode = vid_mode_e'(2'(mode_v));
		cur_rres = rres_v;
		cur_nogfx = nogfx_v;
		cur_vpage = pg;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// memory answers two clocks after each strobe
	initial begin
		mem_rd_stb = 1'b0;
		mem_rd_data = '0;
		forever begin
			@(posedge clk);
			#1;
			mem_rd_stb = rsp_vld[1];
			mem_rd_data = rsp_dat1;
		end
	end

	initial begin
		#(WATCHDOG);
		failure("watchdog expired before the last frame ended");
	end

	// sampled mid cycle, all outputs settled
	always @(negedge clk) begin
		window_limits(cur_rres, hb, he, vb, ve);
		mode_rate(cur_mode, fs, bw);
		if (rst) begin
			assert (!req.valid && !line_start && !frame_start)
				else failure("strobe active during reset");
			tb_h = '0;
			tb_v = '0;
			line_gap = 0;
			frame_gap = 0;
			seen_line = 1'b0;
			seen_frame = 1'b0;
			line_act = 1'b0;
			exp_hires = 1'b0;
			tb_col = 0;
			tb_row = 0;
			req_cnt = 0;
			line_exp = 0;
			rsp_vld = 2'b00;
		end else begin
			assert (line_hires == exp_hires)
				else mismatch("line_hires", int'(exp_hires), int'(line_hires));
			line_gap++;
			frame_gap++;
			if (line_start) begin
				if (seen_line) begin
					assert (line_gap == HTOTAL) else mismatch("line_start period", HTOTAL, line_gap);
					assert (req_cnt == line_exp) else mismatch("requests per line", line_exp, req_cnt);
				end
				if (frame_start) begin
					if (seen_frame) begin
						assert (frame_gap == FRAME_CLKS)
							else mismatch("frame_start period", FRAME_CLKS, frame_gap);
					end
					seen_frame = 1'b1;
					frame_gap = 0;
					tb_v = '0;
					tb_row = 0;
				end else begin
					tb_v = tb_v + 9'd1;
					if (line_act)
						tb_row++;	// rows count active lines only
				end
				seen_line = 1'b1;
				line_gap = 0;
				tb_h = '0;
				tb_col = 0;
				req_cnt = 0;
				exp_hires = (cur_mode == mode_tx);	// latched for the new line
			end else begin
				tb_h = tb_h + 9'd1;
			end
			h_in = (tb_h >= hb) && (tb_h < he);
			v_in = (tb_v >= vb) && (tb_v < ve);
			assert (h_active == h_in) else mismatch("h_active", int'(h_in), int'(h_active));
			assert (v_active == v_in) else mismatch("v_active", int'(v_in), int'(v_active));
			if (tb_h == 9'd80) begin	// config settled, window not yet open
				line_act = v_in;
				line_exp = (v_in && !cur_nogfx) ? int'(he - hb) / int'(fs) : 0;
			end
			if (req.valid) begin
				exp_addr = layout_addr(cur_mode, cur_vpage, tb_col, tb_row, exp_char);
				assert (req.addr == exp_addr)
					else mismatch("req.addr", int'(exp_addr), int'(req.addr));
				assert (req.bw == bw) else mismatch("req.bw", int'(bw), int'(req.bw));
				rsp_new = vid_data_t'($urandom);
				if (cur_mode == mode_tx && tb_col % 4 == 0)
					exp_char = int'(rsp_new);	// char pair for glyph phases
				tb_col++;
				req_cnt++;
				req_total++;
			end
			rsp_vld[1] = rsp_vld[0];
			rsp_vld[0] = req.valid;
			rsp_dat1 = rsp_dat0;
			rsp_dat0 = rsp_new;
		end
	end

	a_frame_on_line: assert property (@(posedge clk) disable iff (rst)
		frame_start |-> line_start)
		else failure("frame_start without line_start");

	a_req_window: assert property (@(posedge clk) disable iff (rst)
		req.valid |-> h_active && v_active && !cur_nogfx)
		else failure("request outside the active window or with nogfx set");

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		cfg_stb = 1'b0;
		cfg_vpage = '0;
		cfg_vconf = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		// one frame per raster res with the mode stepping every line
		for (int f = 0; f < N_FRAMES; f++) begin
			frame_sync();
			for (int l = 0; l < VTOTAL; l++) begin
				if (l != 0)
					line_sync();
				if (f < 4)
					write_config(l % 4, f, 1'b0, $urandom % 256, 1);
				else
					write_config(l % 4, 3, 1'b1, $urandom % 256, 224);	// mid-line, no fetch
			end
		end
		frame_sync();
		if (req_total > 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			failure("no request was seen during the run");
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
video_pkg.sv
video_mode.sv
video_raster.sv
video_addr.sv
video_fetch.sv
video_top.sv
tb_video.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_video
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
PASS_MSG = All tests passed!

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation result is judged by the pass message in its output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
